// ==== files.f ====
+incdir+hw
hw/mec_pkg.sv
hw/modexp_slot.sv
hw/mm_dispatch.sv
hw/modexp_ctrl.sv
dv/tb_mm_model.sv
dv/tb_modexp_ctrl.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench, exit status tells pass or fail
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f files.f --top-module tb_modexp_ctrl -o sim_modexp \
    && ./obj_dir/sim_modexp \
    || exit 1
exit 0

// ==== dv/tb_modexp_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mec_macros.svh"

module tb_modexp_ctrl;

    localparam logic [31:0] P       = 32'h7fff_ffff;   // 2^31 - 1
    localparam int          N_MM    = 12;
    localparam int          N_ME    = 12;
    localparam int          N_PAIR  = 6;
    localparam int          N_JOBS  = N_MM + N_ME + 3 * N_PAIR;
    localparam int          MAX_LAT = 8;
    // 17 exponent bits, a multiply and a square each, with slack for back-pressure
    localparam real         LIMIT   = N_JOBS * 34.0 * (MAX_LAT + 4) * 4 * 100.0;

    logic                   clk;
    logic                   rst_n;
    logic                   start_me, start_mm;
    logic [`MEC_ID_W-1:0]   job_id;
    logic [`MEC_OP_W-1:0]   a, e;
    logic                   mm_ready, mm_done, mm_ovf;
    logic [`MEC_OP_W-1:0]   mm_res, a_mm, b_mm, z;
    logic [2:0]             mm_tag_in, mm_tag_out;
    logic                   en_mm, full, done;
    logic [`MEC_ID_W-1:0]   done_id;

    logic [31:0]            expv [16];
    int                     started [16];
    int                     finished [16];
    int                     accept_cnt;
    int                     done_cnt;

    modexp_ctrl u_dut (
        .clk (clk), .rst_n (rst_n),
        .start_me_i (start_me), .start_mm_i (start_mm),
        .job_id_i (job_id), .a_i (a), .e_i (e),
        .mm_ready_i (mm_ready), .mm_done_i (mm_done),
        .mm_res_i (mm_res), .mm_tag_i (mm_tag_in),
        .en_mm_o (en_mm), .a_mm_o (a_mm), .b_mm_o (b_mm), .mm_tag_o (mm_tag_out),
        .full_o (full), .done_o (done), .done_id_o (done_id), .z_o (z)
    );

    tb_mm_model #(.MOD (P), .MAX_LAT (MAX_LAT)) u_mm (
        .clk (clk), .rst_n (rst_n), .en_i (en_mm), .a_i (a_mm), .b_i (b_mm),
        .tag_i (mm_tag_out), .ready_o (mm_ready), .done_o (mm_done),
        .res_o (mm_res), .tag_o (mm_tag_in), .overflow_o (mm_ovf)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_val(input string name, input logic [63:0] exp_v,
                             input logic [63:0] act_v);
        if (exp_v !== act_v) begin
            $display("error %s expected %0h actual %0h", name, exp_v, act_v);
            $display("** FAIL **");
            $fatal(1, "check failed");
        end
    endtask

    function automatic logic [31:0] mul_mod(input logic [31:0] x, input logic [31:0] y);
        logic [63:0] prod;
        prod = {32'd0, x} * {32'd0, y};
        return 32'(prod % {32'd0, P});
    endfunction

    // plain repeated multiplication, independent of the bit scan
    function automatic logic [31:0] pow_mod(input logic [31:0] x, input logic [31:0] n);
        logic [31:0] r;
        r = 1;
        for (int i = 0; i < n; i++) begin
            r = mul_mod(r, x);
        end
        return r;
    endfunction

    function automatic logic [3:0] free_id();
        logic [3:0] id;
        id = 4'($urandom % 16);
        while (started[id] != finished[id]) id = id + 1;
        return id;
    endfunction

    // one start strobe; record the job only if the controller had room
    task automatic send_job(input logic me, input logic [3:0] id, input logic [31:0] av,
                            input logic [31:0] ev, input logic record);
        start_me = me;
        start_mm = !me;
        job_id   = id;
        a        = av;
        e        = ev;
        if (record && !full) begin
            expv[id]    = me ? pow_mod(av, ev) : mul_mod(av, ev);
            started[id] = started[id] + 1;
            accept_cnt  = accept_cnt + 1;
        end
        @(posedge clk);
        #1;
        start_me = 1'b0;
        start_mm = 1'b0;
    endtask

    task automatic wait_room();
        while (full) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_drain();
        while (done_cnt != accept_cnt || full) begin
            @(posedge clk);
            #1;
        end
    endtask

    //////////////////////////////////////////////////
    // monitor, sampled mid cycle
    //////////////////////////////////////////////////

    always @(negedge clk) begin
        if (rst_n) begin
            check_val("multiplier overflow", 0, 64'(mm_ovf));
            if (en_mm) begin
                // a square multiplies the base by itself
                if (mm_tag_out[1:0] == mec_pkg::OP_SQR) begin
                    check_val("square operands", 64'(a_mm), 64'(b_mm));
                end
                if (mm_tag_out[2]) begin
                    check_val("issue slot1 live", 1,
                              64'(u_dut.u_slot1.state_o != mec_pkg::SLOT_IDLE));
                end else begin
                    check_val("issue slot0 live", 1,
                              64'(u_dut.u_slot0.state_o != mec_pkg::SLOT_IDLE));
                end
            end
            if (done) begin
                if (started[done_id] == finished[done_id]) begin
                    $display("job id %0d completed but was never accepted", done_id);
                    $display("** FAIL **");
                    $fatal(1, "unexpected completion");
                end
                check_val("job result", 64'(expv[done_id]), 64'(z));
                finished[done_id] = finished[done_id] + 1;
                done_cnt = done_cnt + 1;
            end
        end
    end

    initial begin
        #(LIMIT);
        $display("run timed out before all jobs completed");
        $display("** FAIL **");
        $fatal(1, "timeout");
    end

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    initial begin
        void'($urandom(61));
        rst_n      = 1'b0;
        start_me   = 1'b0;
        start_mm   = 1'b0;
        job_id     = '0;
        a          = '0;
        e          = '0;
        accept_cnt = 0;
        done_cnt   = 0;
        for (int i = 0; i < 16; i++) begin
            started[i]  = 0;
            finished[i] = 0;
            expv[i]     = '0;
        end
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // quiet after reset
        repeat (3) begin
            @(negedge clk);
            check_val("reset en_mm", 0, 64'(en_mm));
            check_val("reset done", 0, 64'(done));
            check_val("reset full", 0, 64'(full));
        end
        @(posedge clk);
        #1;

        for (int n = 0; n < N_MM; n++) begin
            wait_room();
            send_job(1'b0, free_id(), $urandom % P, $urandom % P, 1'b1);
        end
        for (int n = 0; n < N_ME; n++) begin
            wait_room();
            send_job(1'b1, free_id(), $urandom % P, $urandom_range(65536, 1), 1'b1);
        end

        // two back to back, then a third that must be dropped
        for (int n = 0; n < N_PAIR; n++) begin
            wait_drain();
            send_job(1'b1, free_id(), $urandom % P, $urandom_range(65536, 1), 1'b1);
            send_job(1'b1, free_id(), $urandom % P, $urandom_range(65536, 1), 1'b1);
            check_val("full with two jobs", 1, 64'(full));
            send_job(n[0], free_id(), $urandom % P, $urandom_range(65536, 1), 1'b0);
        end
        wait_drain();
        repeat (4) @(posedge clk);

        if (done_cnt == accept_cnt && accept_cnt == N_MM + N_ME + 2 * N_PAIR) begin
            $display("** PASS **");
            $finish;
        end else begin
            $display("job count mismatch, %0d accepted, %0d done", accept_cnt, done_cnt);
            $display("** FAIL **");
            $fatal(1, "job count");
        end
    end

endmodule

`default_nettype wire

// ==== dv/tb_mm_model.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mec_macros.svh"

// behavioral multiplier, modular product after a random latency
module tb_mm_model #(
    parameter logic [`MEC_OP_W-1:0] MOD     = 32'h7fff_ffff,
    parameter int                   MAX_LAT = 8
) (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     en_i,
    input  wire [`MEC_OP_W-1:0]     a_i,
    input  wire [`MEC_OP_W-1:0]     b_i,
    input  wire [2:0]               tag_i,
    output logic                    ready_o,
    output logic                    done_o,
    output logic [`MEC_OP_W-1:0]    res_o,
    output logic [2:0]              tag_o,
    output logic                    overflow_o    // issue with no free entry
);

    logic                   valid [4];
    logic [`MEC_OP_W-1:0]   value [4];
    logic [2:0]             tag   [4];
    int                     lat   [4];
    int                     first;
    int                     idx;
    int                     count;
    logic                   found;
    logic [63:0]            prod;

    initial begin
        ready_o    = 1'b0;
        done_o     = 1'b0;
        res_o      = '0;
        tag_o      = '0;
        overflow_o = 1'b0;
        for (int i = 0; i < 4; i++) begin
            valid[i] = 1'b0;
        end
        forever begin
            @(posedge clk);
            #1;
            done_o = 1'b0;
            if (!rst_n) begin
                ready_o = 1'b0;
                for (int i = 0; i < 4; i++) begin
                    valid[i] = 1'b0;
                end
            end else begin
                // retire one due entry, random start point gives out of order
                found = 1'b0;
                first = $urandom % 4;
                for (int k = 0; k < 4; k++) begin
                    idx = (first + k) % 4;
                    if (!found && valid[idx] && lat[idx] == 0) begin
                        done_o     = 1'b1;
                        res_o      = value[idx];
                        tag_o      = tag[idx];
                        valid[idx] = 1'b0;
                        found      = 1'b1;
                    end
                end
                for (int i = 0; i < 4; i++) begin
                    if (valid[i] && lat[i] > 0) lat[i] = lat[i] - 1;
                end
                if (en_i) begin
                    found = 1'b0;
                    prod  = {32'd0, a_i} * {32'd0, b_i};
                    for (int i = 0; i < 4; i++) begin
                        if (!found && !valid[i]) begin
                            valid[i] = 1'b1;
                            value[i] = `MEC_OP_W'(prod % {32'd0, MOD});
                            tag[i]   = tag_i;
                            lat[i]   = $urandom_range(MAX_LAT - 1, 0);
                            found    = 1'b1;
                        end
                    end
                    if (!found) overflow_o = 1'b1;
                end
                count = 0;
                for (int i = 0; i < 4; i++) begin
                    if (valid[i]) count = count + 1;
                end
                // room for two issues still on their way
                ready_o = (count <= 2) && ($urandom % 4 != 0);
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/modexp_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mec_macros.svh"

module modexp_ctrl (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     start_me_i,
    input  wire                     start_mm_i,
    input  wire [`MEC_ID_W-1:0]     job_id_i,
    input  wire [`MEC_OP_W-1:0]     a_i,
    input  wire [`MEC_OP_W-1:0]     e_i,
    // montgomery multiplier
    input  wire                     mm_ready_i,
    input  wire                     mm_done_i,
    input  wire [`MEC_OP_W-1:0]     mm_res_i,
    input  wire [2:0]               mm_tag_i,
    output logic                    en_mm_o,
    output logic [`MEC_OP_W-1:0]    a_mm_o,
    output logic [`MEC_OP_W-1:0]    b_mm_o,
    output logic [2:0]              mm_tag_o,
    // status and results
    output logic                    full_o,
    output logic                    done_o,
    output logic [`MEC_ID_W-1:0]    done_id_o,
    output logic [`MEC_OP_W-1:0]    z_o
);

    // dispatcher to slots
    logic                   start0, start1, start_kind;
    logic                   gnt0, gnt1;
    logic                   res_valid0, res_valid1;
    mec_pkg::mec_op_e       res_op;
    logic [`MEC_OP_W-1:0]   res;

    // slots to dispatcher
    mec_pkg::slot_state_e   state0, state1;
    logic                   req0, req1;
    logic [`MEC_OP_W-1:0]   req_a0, req_b0, req_a1, req_b1;
    mec_pkg::mec_op_e       req_op0, req_op1;
    logic                   sdone0, sdone1;
    logic [`MEC_ID_W-1:0]   sid0, sid1;
    logic [`MEC_OP_W-1:0]   sz0, sz1;

    //////////////////////////////////////////////////
    // two job slots side by side
    //////////////////////////////////////////////////

    modexp_slot u_slot0 (
        .clk (clk), .rst_n (rst_n),
        .start_i (start0), .start_me_i (start_kind),
        .job_id_i (job_id_i), .a_i (a_i), .e_i (e_i),
        .gnt_i (gnt0), .res_valid_i (res_valid0), .res_op_i (res_op), .res_i (res),
        .state_o (state0), .req_o (req0), .req_a_o (req_a0), .req_b_o (req_b0),
        .req_op_o (req_op0), .done_o (sdone0), .done_id_o (sid0), .z_o (sz0)
    );

    modexp_slot u_slot1 (
        .clk (clk), .rst_n (rst_n),
        .start_i (start1), .start_me_i (start_kind),
        .job_id_i (job_id_i), .a_i (a_i), .e_i (e_i),
        .gnt_i (gnt1), .res_valid_i (res_valid1), .res_op_i (res_op), .res_i (res),
        .state_o (state1), .req_o (req1), .req_a_o (req_a1), .req_b_o (req_b1),
        .req_op_o (req_op1), .done_o (sdone1), .done_id_o (sid1), .z_o (sz1)
    );

    // allocation, multiplier port, done merge
    mm_dispatch u_dispatch (
        .clk (clk), .rst_n (rst_n),
        .start_me_i (start_me_i), .start_mm_i (start_mm_i),
        .slot0_state_i (state0), .slot0_req_i (req0), .slot0_a_i (req_a0),
        .slot0_b_i (req_b0), .slot0_op_i (req_op0), .slot0_done_i (sdone0),
        .slot0_id_i (sid0), .slot0_z_i (sz0),
        .slot1_state_i (state1), .slot1_req_i (req1), .slot1_a_i (req_a1),
        .slot1_b_i (req_b1), .slot1_op_i (req_op1), .slot1_done_i (sdone1),
        .slot1_id_i (sid1), .slot1_z_i (sz1),
        .mm_ready_i (mm_ready_i), .mm_done_i (mm_done_i),
        .mm_res_i (mm_res_i), .mm_tag_i (mm_tag_i),
        .start0_o (start0), .start1_o (start1), .start_kind_o (start_kind),
        .gnt0_o (gnt0), .gnt1_o (gnt1),
        .res_valid0_o (res_valid0), .res_valid1_o (res_valid1),
        .res_op_o (res_op), .res_o (res),
        .en_mm_o (en_mm_o), .a_mm_o (a_mm_o), .b_mm_o (b_mm_o), .mm_tag_o (mm_tag_o),
        .full_o (full_o), .done_o (done_o), .done_id_o (done_id_o), .z_o (z_o)
    );

endmodule

`default_nettype wire

// ==== hw/mm_dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mec_macros.svh"

module mm_dispatch (
    input  wire                          clk,
    input  wire                          rst_n,
    // job starts from outside
    input  wire                          start_me_i,
    input  wire                          start_mm_i,
    // slot 0
    input  wire mec_pkg::slot_state_e    slot0_state_i,
    input  wire                          slot0_req_i,
    input  wire [`MEC_OP_W-1:0]          slot0_a_i,
    input  wire [`MEC_OP_W-1:0]          slot0_b_i,
    input  wire mec_pkg::mec_op_e        slot0_op_i,
    input  wire                          slot0_done_i,
    input  wire [`MEC_ID_W-1:0]          slot0_id_i,
    input  wire [`MEC_OP_W-1:0]          slot0_z_i,
    // slot 1
    input  wire mec_pkg::slot_state_e    slot1_state_i,
    input  wire                          slot1_req_i,
    input  wire [`MEC_OP_W-1:0]          slot1_a_i,
    input  wire [`MEC_OP_W-1:0]          slot1_b_i,
    input  wire mec_pkg::mec_op_e        slot1_op_i,
    input  wire                          slot1_done_i,
    input  wire [`MEC_ID_W-1:0]          slot1_id_i,
    input  wire [`MEC_OP_W-1:0]          slot1_z_i,
    // multiplier return
    input  wire                          mm_ready_i,
    input  wire                          mm_done_i,
    input  wire [`MEC_OP_W-1:0]          mm_res_i,
    input  wire [2:0]                    mm_tag_i,
    // to slots
    output logic                         start0_o,
    output logic                         start1_o,
    output logic                         start_kind_o,  // 1: me job
    output logic                         gnt0_o,
    output logic                         gnt1_o,
    output logic                         res_valid0_o,
    output logic                         res_valid1_o,
    output mec_pkg::mec_op_e             res_op_o,
    output logic [`MEC_OP_W-1:0]         res_o,
    // multiplier issue
    output logic                         en_mm_o,
    output logic [`MEC_OP_W-1:0]         a_mm_o,
    output logic [`MEC_OP_W-1:0]         b_mm_o,
    output logic [2:0]                   mm_tag_o,
    // to outside
    output logic                         full_o,
    output logic                         done_o,
    output logic [`MEC_ID_W-1:0]         done_id_o,
    output logic [`MEC_OP_W-1:0]         z_o
);

    logic start_any;
    logic idle0;
    logic idle1;

    //////////////////////////////////////////////////
    // slot allocation
    //////////////////////////////////////////////////

    assign start_any    = start_me_i | start_mm_i;
    assign start_kind_o = start_me_i;   // me wins when both strobes come
    assign idle0        = (slot0_state_i == mec_pkg::SLOT_IDLE);
    assign idle1        = (slot1_state_i == mec_pkg::SLOT_IDLE);

    // lowest idle slot takes it, none idle means the start is dropped
    assign start0_o = start_any && idle0;
    assign start1_o = start_any && !idle0 && idle1;
    assign full_o   = !idle0 && !idle1;

    //////////////////////////////////////////////////
    // issue arbitration, slot 0 first
    //////////////////////////////////////////////////

    assign gnt0_o = mm_ready_i && slot0_req_i;
    assign gnt1_o = mm_ready_i && slot1_req_i && !slot0_req_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            en_mm_o <= 1'b0;
        end else begin
            en_mm_o <= gnt0_o | gnt1_o;
        end
    end

    // operands and tag captured with the grant
    always_ff @(posedge clk) begin
        if (gnt0_o) begin
            a_mm_o   <= slot0_a_i;
            b_mm_o   <= slot0_b_i;
            mm_tag_o <= {1'b0, slot0_op_i};
        end else if (gnt1_o) begin
            a_mm_o   <= slot1_a_i;
            b_mm_o   <= slot1_b_i;
            mm_tag_o <= {1'b1, slot1_op_i};
        end
    end

    //////////////////////////////////////////////////
    // result routing by tag
    //////////////////////////////////////////////////

    assign res_valid0_o = mm_done_i && !mm_tag_i[2];
    assign res_valid1_o = mm_done_i && mm_tag_i[2];
    assign res_op_o     = mec_pkg::mec_op_e'(mm_tag_i[1:0]);
    assign res_o        = mm_res_i;

    //////////////////////////////////////////////////
    // completion merge
    //////////////////////////////////////////////////

    // one result per cycle, so the two done pulses never overlap
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_o <= 1'b0;
        end else begin
            done_o <= slot0_done_i | slot1_done_i;
        end
    end

    always_ff @(posedge clk) begin
        if (slot0_done_i) begin
            done_id_o <= slot0_id_i;
            z_o       <= slot0_z_i;
        end else if (slot1_done_i) begin
            done_id_o <= slot1_id_i;
            z_o       <= slot1_z_i;
        end
    end

endmodule

`default_nettype wire

// ==== hw/modexp_slot.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mec_macros.svh"

module modexp_slot (
    input  wire                          clk,
    input  wire                          rst_n,
    // job load
    input  wire                          start_i,
    input  wire                          start_me_i,   // 1: exponentiation, 0: single mm
    input  wire [`MEC_ID_W-1:0]          job_id_i,
    input  wire [`MEC_OP_W-1:0]          a_i,
    input  wire [`MEC_OP_W-1:0]          e_i,          // second operand for an mm job
    // from the dispatcher
    input  wire                          gnt_i,
    input  wire                          res_valid_i,
    input  wire mec_pkg::mec_op_e        res_op_i,
    input  wire [`MEC_OP_W-1:0]          res_i,
    // to the dispatcher
    output mec_pkg::slot_state_e         state_o,
    output logic                         req_o,
    output logic [`MEC_OP_W-1:0]         req_a_o,
    output logic [`MEC_OP_W-1:0]         req_b_o,
    output mec_pkg::mec_op_e             req_op_o,
    output logic                         done_o,
    output logic [`MEC_ID_W-1:0]         done_id_o,
    output logic [`MEC_OP_W-1:0]         z_o
);

    mec_pkg::slot_state_e   state_q;

    logic [`MEC_OP_W-1:0]   base_q;     // a, a^2, a^4 ...
    logic [`MEC_OP_W-1:0]   res_q;      // running product
    logic [`MEC_OP_W-1:0]   exp_q;      // remaining exponent bits
    logic [`MEC_ID_W-1:0]   id_q;
    logic                   is_me_q;

    logic                   mul_pend_q;  // OP_MUL or OP_SINGLE in flight
    logic                   sqr_pend_q;  // OP_SQR in flight
    logic                   owe_req_q;   // a request is due whatever the exponent says

    logic [`MEC_OP_W-1:0]   exp_d;
    logic                   mul_pend_d;
    logic                   sqr_pend_d;
    logic                   owe_req_d;
    logic                   can_req;
    logic                   finish;

    //////////////////////////////////////////////////
    // request side
    //////////////////////////////////////////////////

    assign req_o   = (state_q == mec_pkg::SLOT_REQ);
    assign state_o = state_q;

    // square follows a granted multiply, else the low bit picks
    always_comb begin
        if (!is_me_q) begin
            req_op_o = mec_pkg::OP_SINGLE;
        end else if (owe_req_q || !exp_q[0]) begin
            req_op_o = mec_pkg::OP_SQR;
        end else begin
            req_op_o = mec_pkg::OP_MUL;
        end
    end

    always_comb begin
        req_a_o = base_q;
        case (req_op_o)
            mec_pkg::OP_MUL: req_b_o = res_q;
            mec_pkg::OP_SQR: req_b_o = base_q;
            default:         req_b_o = exp_q;   // mm job keeps b in the exponent reg
        endcase
    end

    //////////////////////////////////////////////////
    // bookkeeping for grants and returning results
    //////////////////////////////////////////////////

    always_comb begin
        exp_d      = exp_q;
        mul_pend_d = mul_pend_q;
        sqr_pend_d = sqr_pend_q;
        owe_req_d  = owe_req_q;

        if (res_valid_i) begin
            if (res_op_i == mec_pkg::OP_SQR) begin
                sqr_pend_d = 1'b0;
            end else begin
                mul_pend_d = 1'b0;
            end
        end

        if (gnt_i) begin
            case (req_op_o)
                mec_pkg::OP_MUL: begin
                    mul_pend_d = 1'b1;
                    if (exp_q[`MEC_OP_W-1:1] == '0) begin
                        exp_d = '0;         // last bit, no square after it
                    end else begin
                        owe_req_d = 1'b1;   // square comes next
                    end
                end
                mec_pkg::OP_SQR: begin
                    sqr_pend_d = 1'b1;
                    owe_req_d  = 1'b0;
                    exp_d      = exp_q >> 1;
                end
                default: begin
                    mul_pend_d = 1'b1;
                    owe_req_d  = 1'b0;
                    exp_d      = '0;
                end
            endcase
        end

        finish = (exp_d == '0) && !mul_pend_d && !sqr_pend_d && !owe_req_d;

        // a multiply must see the previous product, a square must see the base
        if (owe_req_d) begin
            can_req = 1'b1;
        end else begin
            can_req = (exp_d != '0) && !sqr_pend_d && !(exp_d[0] && mul_pend_d);
        end
    end

    //////////////////////////////////////////////////
    // control state
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= mec_pkg::SLOT_IDLE;
            is_me_q    <= 1'b0;
            mul_pend_q <= 1'b0;
            sqr_pend_q <= 1'b0;
            owe_req_q  <= 1'b0;
            done_o     <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (start_i) begin
                state_q    <= mec_pkg::SLOT_REQ;
                is_me_q    <= start_me_i;
                mul_pend_q <= 1'b0;
                sqr_pend_q <= 1'b0;
                owe_req_q  <= !start_me_i;   // mm job asks once
            end else if (state_q != mec_pkg::SLOT_IDLE) begin
                mul_pend_q <= mul_pend_d;
                sqr_pend_q <= sqr_pend_d;
                owe_req_q  <= owe_req_d;
                if (finish) begin
                    state_q <= mec_pkg::SLOT_IDLE;
                    done_o  <= 1'b1;
                end else if (can_req) begin
                    state_q <= mec_pkg::SLOT_REQ;
                end else begin
                    state_q <= mec_pkg::SLOT_WAIT;
                end
            end
        end
    end

    // operands and result
    always_ff @(posedge clk) begin
        if (start_i) begin
            base_q <= a_i;
            exp_q  <= e_i;
            id_q   <= job_id_i;
            res_q  <= {{(`MEC_OP_W-1){1'b0}}, start_me_i};  // 1 for me, 0 for mm
        end else begin
            exp_q <= exp_d;
            if (res_valid_i) begin
                if (res_op_i == mec_pkg::OP_SQR) begin
                    base_q <= res_i;
                end else begin
                    res_q <= res_i;
                end
            end
        end
    end

    // stable through the done cycle, a new start loads only at its end
    assign done_id_o = id_q;
    assign z_o       = res_q;

endmodule

`default_nettype wire

// ==== hw/mec_pkg.sv ====
`default_nettype none

package mec_pkg;

    //////////////////////////////////////////////////
    // kind of multiplication, low part of the tag
    //////////////////////////////////////////////////
    typedef enum logic [1:0] {
        OP_MUL    = 2'd0,   // base * result
        OP_SQR    = 2'd1,   // base * base
        OP_SINGLE = 2'd2    // one-shot multiply job
    } mec_op_e;

    // per-slot sequencing state
    // the dispatcher looks at SLOT_IDLE to place new jobs
    typedef enum logic [1:0] {
        SLOT_IDLE = 2'd0,
        SLOT_REQ  = 2'd1,   // request up towards the multiplier
        SLOT_WAIT = 2'd2    // products in flight, nothing to ask
    } slot_state_e;

endpackage

`default_nettype wire

// ==== hw/mec_macros.svh ====
`ifndef MEC_MACROS_SVH
`define MEC_MACROS_SVH

//////////////////////////////////////////////////
// widths shared by the controller and its users
//////////////////////////////////////////////////

// operand width, base / exponent / result all use it
`define MEC_OP_W 32

// job number, carried from start to done
`define MEC_ID_W 4

// tag on the multiplier port is {slot, op}
// slot is one bit, op is mec_pkg::mec_op_e
// so the tag is three bits wide

`endif
